// ==== verilog.f ====
src/rtos_cfg_pkg.sv
src/rtos_op_pkg.sv
src/rtos_wb_decode.sv
src/rtos_ready_queue.sv
src/rtos_event_flag.sv
src/rtos_systim.sv
src/rtos_dispatch.sv
src/rtos_top.sv
verification/rtos_tb_sva.sv
verification/rtos_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the RTOS testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f verilog.f --top-module rtos_tb -o rtos_sim

./obj_dir/rtos_sim | tee sim.log

if grep -qx "Verification passed" sim.log; then
    exit 0
fi
exit 1

// ==== verification/rtos_tb.sv ====
/*
 * RTOS testbench
 * Drives the Wishbone bus, keeps a reference model of the kernel state
 * and compares every read against it
 */
module rtos_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rtos_cfg_pkg::*;
    import rtos_op_pkg::*;

    localparam int TMAX_TSKID      = 15;
    localparam int FLGPTN_WIDTH    = 32;
    localparam int CLOCK_RATE      = 100000000;
    localparam int TSKID_WIDTH     = $clog2(TMAX_TSKID + 1);
    localparam int RDY_OPS         = 40;
    localparam int IDLE_CYCLES     = 50;
    localparam int ACK_LIMIT       = 16;
    localparam int ACCESSES        = 44 + 3 * RDY_OPS;
    localparam int WATCHDOG_CYCLES = ACCESSES * 20 + IDLE_CYCLES + 100;

    logic                    clk;
    logic                    arst_n_i;
    logic [15:0]             wb_adr_i;
    logic [31:0]             wb_dat_i;
    logic                    wb_we_i;
    logic [3:0]              wb_sel_i;
    logic                    wb_stb_i;
    logic                    wb_cyc_i;
    logic [31:0]             wb_dat_o;
    logic                    wb_ack_o;
    logic [FLGPTN_WIDTH-1:0] ext_set_flg_i;
    logic                    irq_o;

    int errors = 0;
    int seed   = 32'h3d5b9b99;

    // reference model
    logic [TMAX_TSKID:0]    m_rdy;
    logic [31:0]            m_flg;
    logic [31:0]            m_ena;
    logic [TSKID_WIDTH-1:0] m_run;
    logic                   m_irq_en;
    logic                   m_irq_force;

    // reads waiting for comparison
    string       name_q[$];
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];

    rtos_top #(
        .TMAX_TSKID  (TMAX_TSKID),
        .FLGPTN_WIDTH(FLGPTN_WIDTH),
        .CLOCK_RATE  (CLOCK_RATE)
    ) dut_i (
        .clk, .arst_n_i,
        .wb_adr_i, .wb_dat_i, .wb_we_i, .wb_sel_i, .wb_stb_i, .wb_cyc_i,
        .wb_dat_o, .wb_ack_o, .ext_set_flg_i, .irq_o
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // reference
    function automatic logic [31:0] top_of(input logic [TMAX_TSKID:0] bits);
        for (int i = 1; i <= TMAX_TSKID; i++) begin
            if (bits[i]) begin
                return 32'(i);
            end
        end
        return 32'd0;
    endfunction

    function automatic logic [31:0] expected_value(input logic [7:0] op, input logic [7:0] id);
        logic [31:0] top;
        top = top_of(m_rdy);
        case (op)
            SYS_CFG: begin
                case (id)
                    SYS_CFG_CORE_ID:    return CORE_ID;
                    SYS_CFG_VERSION:    return CORE_VERSION;
                    SYS_CFG_CLOCK_RATE: return 32'(CLOCK_RATE);
                    SYS_CFG_TMAX_TSKID: return 32'(TMAX_TSKID);
                    default:            return 32'd0;
                endcase
            end
            CPU_CTL: begin
                case (id)
                    CPU_CTL_TOP_TSKID:  return top;
                    CPU_CTL_RUN_TSKID:  return 32'(m_run);
                    CPU_CTL_COPY_TSKID: return top;
                    CPU_CTL_IRQ_EN:     return {31'd0, m_irq_en};
                    CPU_CTL_IRQ_STS:
                        return {31'd0, (m_irq_en && (32'(m_run) != top)) || m_irq_force};
                    default:            return 32'd0;
                endcase
            end
            REF_RDYQUE: return 32'(m_rdy);
            REF_FLGPTN: return m_flg;
            default:    return 32'd0;
        endcase
    endfunction

    task automatic update_model(input logic [7:0] op, input logic [7:0] id,
                                input logic [31:0] data);
        case (op)
            WUP_TSK: if (id >= 1 && id <= TMAX_TSKID) m_rdy[id[TSKID_WIDTH-1:0]] = 1'b1;
            SLP_TSK: if (id >= 1 && id <= TMAX_TSKID) m_rdy[id[TSKID_WIDTH-1:0]] = 1'b0;
            SET_FLG:     m_flg = m_flg | data;
            CLR_FLG:     m_flg = m_flg & data;
            ENA_FLG_EXT: m_ena = data;
            CPU_CTL: begin
                case (id)
                    CPU_CTL_RUN_TSKID:  m_run = data[TSKID_WIDTH-1:0];
                    CPU_CTL_COPY_TSKID: m_run = data[TSKID_WIDTH-1:0];
                    CPU_CTL_IRQ_EN:     m_irq_en = data[0];
                    CPU_CTL_IRQ_FORCE:  m_irq_force = data[0];
                    default:            ;
                endcase
            end
            default: ;
        endcase
    endtask

    // --------------------
    // bus
    task automatic wait_ack(input logic [15:0] adr);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack_o && n < ACK_LIMIT);
        if (!wb_ack_o) begin
            $display("no ack for the access to address %h", adr);
            errors++;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] adr, input logic [31:0] data,
                             input logic [3:0] sel);
        @(posedge clk);
        #1;
        wb_adr_i = adr;
        wb_dat_i = data;
        wb_sel_i = sel;
        wb_we_i  = 1'b1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wait_ack(adr);
        if (&sel) begin
            update_model(adr[15:8], adr[7:0], data);
        end
    endtask

    task automatic read_reg(input logic [15:0] adr, output logic [31:0] data);
        @(posedge clk);
        #1;
        wb_adr_i = adr;
        wb_sel_i = 4'hf;
        wb_we_i  = 1'b0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wait_ack(adr);
        data = wb_dat_o;
    endtask

    task automatic expect_read(input logic [7:0] op, input logic [7:0] id, input string name);
        logic [31:0] exp;
        logic [31:0] got;
        exp = expected_value(op, id);
        read_reg({op, id}, got);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // copy on read moves the run task to the top task
    task automatic copy_top();
        expect_read(CPU_CTL, CPU_CTL_COPY_TSKID, "wb_dat_o[COPY_TSKID]");
        m_run = TSKID_WIDTH'(top_of(m_rdy));
    endtask

    task automatic drive_ext(input logic [FLGPTN_WIDTH-1:0] val);
        @(posedge clk);
        #1;
        ext_set_flg_i = val;
        repeat (2) @(posedge clk);
        #1;
        ext_set_flg_i = '0;
        m_flg = m_flg | (val & m_ena);
    endtask

    task automatic wait_irq(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        while (irq_o !== level && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (irq_o !== level) begin
            $display("irq_o did not reach %0d within %0d cycles (%s)", level, max_cycles, what);
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    // compare process
    always @(posedge clk) begin
        while (got_q.size() > 0) begin
            check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    // --------------------
    // stimulus
    initial begin
        logic [7:0]  op;
        logic [7:0]  id;
        logic [31:0] top;
        logic [31:0] tim_lo;
        logic [31:0] tim_hi;
        logic [63:0] tim_load;
        logic [63:0] tim_got;
        arst_n_i      = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        wb_we_i       = 1'b0;
        wb_sel_i      = '0;
        wb_stb_i      = 1'b0;
        wb_cyc_i      = 1'b0;
        ext_set_flg_i = '0;
        m_rdy         = '0;
        m_flg         = '0;
        m_ena         = '0;
        m_run         = '0;
        m_irq_en      = 1'b0;
        m_irq_force   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        // configuration and an unmapped address
        expect_read(SYS_CFG, SYS_CFG_CORE_ID, "wb_dat_o[CORE_ID]");
        expect_read(SYS_CFG, SYS_CFG_VERSION, "wb_dat_o[VERSION]");
        expect_read(SYS_CFG, SYS_CFG_CLOCK_RATE, "wb_dat_o[CLOCK_RATE]");
        expect_read(SYS_CFG, SYS_CFG_TMAX_TSKID, "wb_dat_o[TMAX_TSKID]");
        expect_read(SYS_CFG, 8'h02, "wb_dat_o[SYS_CFG 02]");
        expect_read(8'h55, 8'h00, "wb_dat_o[unmapped]");

        // ready queue with ids beyond the range
        for (int k = 0; k < RDY_OPS; k++) begin
            id = 8'({$random(seed)} % (TMAX_TSKID + 3));
            op = ({$random(seed)} % 3 == 0) ? SLP_TSK : WUP_TSK;
            write_reg({op, id}, 32'd0, 4'hf);
            expect_read(REF_RDYQUE, 8'h00, "wb_dat_o[REF_RDYQUE]");
            expect_read(CPU_CTL, CPU_CTL_TOP_TSKID, "wb_dat_o[TOP_TSKID]");
        end

        // event flags
        write_reg({SET_FLG, 8'h00}, $random(seed), 4'hf);
        expect_read(REF_FLGPTN, 8'h00, "wb_dat_o[REF_FLGPTN]");
        write_reg({CLR_FLG, 8'h00}, $random(seed), 4'hf);
        expect_read(REF_FLGPTN, 8'h00, "wb_dat_o[REF_FLGPTN]");
        write_reg({SET_FLG, 8'h00}, 32'hffff_ffff, 4'b0111);
        expect_read(REF_FLGPTN, 8'h00, "wb_dat_o[REF_FLGPTN]");
        write_reg({ENA_FLG_EXT, 8'h00}, 32'h0f0f_ff00, 4'hf);
        drive_ext($random(seed));
        expect_read(REF_FLGPTN, 8'h00, "wb_dat_o[REF_FLGPTN]");
        write_reg({CLR_FLG, 8'h00}, 32'h0000_00ff, 4'hf);
        write_reg({ENA_FLG_EXT, 8'h00}, 32'd0, 4'hf);
        drive_ext($random(seed));
        expect_read(REF_FLGPTN, 8'h00, "wb_dat_o[REF_FLGPTN]");

        // switch interrupt
        write_reg({WUP_TSK, 8'd3}, 32'd0, 4'hf);
        copy_top();
        top = top_of(m_rdy);
        write_reg({CPU_CTL, CPU_CTL_IRQ_EN}, 32'd1, 4'hf);
        repeat (3) @(posedge clk);
        #1;
        check_value("irq_o", {31'd0, irq_o}, 32'd0);
        write_reg({CPU_CTL, CPU_CTL_RUN_TSKID}, top ^ 32'd1, 4'hf);
        wait_irq(1'b1, 4, "run differs from top");
        expect_read(CPU_CTL, CPU_CTL_IRQ_STS, "wb_dat_o[IRQ_STS]");
        expect_read(CPU_CTL, CPU_CTL_IRQ_EN, "wb_dat_o[IRQ_EN]");
        copy_top();
        wait_irq(1'b0, 2, "after copy of the top task");
        expect_read(CPU_CTL, CPU_CTL_RUN_TSKID, "wb_dat_o[RUN_TSKID]");

        // force with the enable clear
        write_reg({CPU_CTL, CPU_CTL_IRQ_EN}, 32'd0, 4'hf);
        write_reg({CPU_CTL, CPU_CTL_RUN_TSKID}, top ^ 32'd1, 4'hf);
        repeat (4) @(posedge clk);
        #1;
        check_value("irq_o", {31'd0, irq_o}, 32'd0);
        write_reg({CPU_CTL, CPU_CTL_IRQ_FORCE}, 32'd1, 4'hf);
        wait_irq(1'b1, 4, "force set");
        expect_read(CPU_CTL, CPU_CTL_IRQ_STS, "wb_dat_o[IRQ_STS]");
        write_reg({CPU_CTL, CPU_CTL_IRQ_FORCE}, 32'd0, 4'hf);
        wait_irq(1'b0, 2, "force cleared");
        copy_top();

        // system time with the low half close to the carry
        tim_load = {$random(seed) & 32'h7fff_ffff, 32'hffff_fff0};
        write_reg({SET_PSCL, 8'h00}, 32'd0, 4'hf);
        write_reg({SYSTIM_LO, 8'h00}, tim_load[31:0], 4'hf);
        write_reg({SYSTIM_HI, 8'h00}, tim_load[63:32], 4'hf);
        write_reg({SET_TIM, 8'h00}, 32'd0, 4'hf);
        repeat (IDLE_CYCLES) @(posedge clk);
        write_reg({GET_TIM, 8'h00}, 32'd0, 4'hf);
        read_reg({SYSTIM_LO, 8'h00}, tim_lo);
        read_reg({SYSTIM_HI, 8'h00}, tim_hi);
        tim_got = {tim_hi, tim_lo};
        if (tim_got < tim_load || tim_got > tim_load + 64'(IDLE_CYCLES + 10)) begin
            $display("system time %h is outside the range from %h to %h",
                     tim_got, tim_load, tim_load + 64'(IDLE_CYCLES + 10));
            errors++;
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("errors: %0d", errors);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== verification/rtos_tb_sva.sv ====
/*
 * Bus handshake and interrupt assertions
 * Bound into the Wishbone decoder
 */
module rtos_tb_sva (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic                                  wb_cyc_i,
    input  logic                                  wb_stb_i,
    input  logic                                  wb_ack_i,
    input  logic                                  irq_i,
    input  logic                                  irq_enable_i,
    input  logic                                  cmd_valid_i,
    input  logic                                  cmd_we_i,
    input  rtos_op_pkg::op_e                      cmd_op_i,
    input  logic [rtos_cfg_pkg::ID_WIDTH-1:0]     cmd_id_i,
    input  logic [rtos_cfg_pkg::WB_DAT_WIDTH-1:0] cmd_data_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import rtos_op_pkg::*;

    logic force_seen;

    // mirrors the force bit of the dispatcher
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            force_seen <= 1'b0;
        end else if (cmd_valid_i && cmd_we_i && cmd_op_i == CPU_CTL &&
                     cmd_id_i == CPU_CTL_IRQ_FORCE) begin
            force_seen <= cmd_data_i[0];
        end
    end

    ack_single: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ack_i |=> !wb_ack_i)
        else $error("ack held high for two cycles");

    ack_after_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(wb_ack_i) |-> $past(wb_cyc_i && wb_stb_i))
        else $error("ack rose without a strobe");

    irq_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
        (!irq_enable_i && !force_seen) |-> !irq_i)
        else $error("irq high with enable and force clear");

endmodule

bind rtos_wb_decode rtos_tb_sva sva_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_ack_i    (wb_ack_o),
    .irq_i       (irq_i),
    .irq_enable_i(irq_enable_i),
    .cmd_valid_i (cmd_valid_o),
    .cmd_we_i    (cmd_we_o),
    .cmd_op_i    (cmd_op_o),
    .cmd_id_i    (cmd_id_o),
    .cmd_data_i  (cmd_data_o)
);

// ==== src/rtos_top.sv ====
/*
 * RTOS top level
 * Wishbone decode, kernel objects and dispatch
 */
module rtos_top #(
    parameter int TMAX_TSKID   = rtos_cfg_pkg::DEF_TMAX_TSKID,
    parameter int FLGPTN_WIDTH = rtos_cfg_pkg::DEF_FLGPTN_WIDTH,
    parameter int CLOCK_RATE   = rtos_cfg_pkg::DEF_CLOCK_RATE
) (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic [rtos_cfg_pkg::WB_ADR_WIDTH-1:0] wb_adr_i,
    input  logic [rtos_cfg_pkg::WB_DAT_WIDTH-1:0] wb_dat_i,
    input  logic                                  wb_we_i,
    input  logic [rtos_cfg_pkg::WB_SEL_WIDTH-1:0] wb_sel_i,
    input  logic                                  wb_stb_i,
    input  logic                                  wb_cyc_i,
    output logic [rtos_cfg_pkg::WB_DAT_WIDTH-1:0] wb_dat_o,
    output logic                                  wb_ack_o,
    input  logic [FLGPTN_WIDTH-1:0]               ext_set_flg_i,
    output logic                                  irq_o
);
    import rtos_cfg_pkg::*;
    import rtos_op_pkg::*;

    localparam int TSKID_WIDTH = $clog2(TMAX_TSKID + 1);

    // command pulse
    logic                    cmd_valid;
    logic                    cmd_we;
    op_e                     cmd_op;
    logic [ID_WIDTH-1:0]     cmd_id;
    logic [WB_DAT_WIDTH-1:0] cmd_data;

    // status
    logic [TMAX_TSKID:1]     rdy_bits;
    logic [TSKID_WIDTH-1:0]  top_tskid;
    logic [TSKID_WIDTH-1:0]  run_tskid;
    logic                    irq_enable;
    logic [FLGPTN_WIDTH-1:0] flgptn;
    logic [SYSTIM_WIDTH-1:0] systim_rd;

    rtos_wb_decode #(
        .TMAX_TSKID  (TMAX_TSKID),
        .FLGPTN_WIDTH(FLGPTN_WIDTH),
        .CLOCK_RATE  (CLOCK_RATE)
    ) decode_i (
        .clk, .arst_n_i,
        .wb_adr_i, .wb_dat_i, .wb_we_i, .wb_sel_i, .wb_cyc_i, .wb_stb_i,
        .wb_ack_o, .wb_dat_o,
        .rdy_bits_i(rdy_bits), .top_tskid_i(top_tskid), .run_tskid_i(run_tskid),
        .irq_enable_i(irq_enable), .irq_i(irq_o), .flgptn_i(flgptn),
        .systim_rd_i(systim_rd),
        .cmd_valid_o(cmd_valid), .cmd_we_o(cmd_we), .cmd_op_o(cmd_op),
        .cmd_id_o(cmd_id), .cmd_data_o(cmd_data)
    );

    rtos_ready_queue #(.TMAX_TSKID(TMAX_TSKID)) ready_queue_i (
        .clk, .arst_n_i,
        .cmd_valid_i(cmd_valid), .cmd_op_i(cmd_op), .cmd_id_i(cmd_id),
        .rdy_bits_o(rdy_bits), .top_tskid_o(top_tskid)
    );

    rtos_event_flag #(.FLGPTN_WIDTH(FLGPTN_WIDTH)) event_flag_i (
        .clk, .arst_n_i,
        .cmd_valid_i(cmd_valid), .cmd_op_i(cmd_op), .cmd_data_i(cmd_data),
        .ext_set_flg_i, .flgptn_o(flgptn)
    );

    rtos_systim systim_i (
        .clk, .arst_n_i,
        .cmd_valid_i(cmd_valid), .cmd_op_i(cmd_op), .cmd_data_i(cmd_data),
        .systim_rd_o(systim_rd)
    );

    rtos_dispatch #(.TMAX_TSKID(TMAX_TSKID)) dispatch_i (
        .clk, .arst_n_i,
        .cmd_valid_i(cmd_valid), .cmd_we_i(cmd_we), .cmd_op_i(cmd_op),
        .cmd_id_i(cmd_id), .cmd_data_i(cmd_data), .top_tskid_i(top_tskid),
        .run_tskid_o(run_tskid), .irq_enable_o(irq_enable), .irq_o
    );

endmodule

// ==== src/rtos_dispatch.sv ====
/*
 * Dispatcher
 * Run-task register and the task switch interrupt
 */
module rtos_dispatch #(
    parameter int TMAX_TSKID = rtos_cfg_pkg::DEF_TMAX_TSKID,
    localparam int TSKID_WIDTH = $clog2(TMAX_TSKID + 1)
) (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic                                  cmd_valid_i,
    input  logic                                  cmd_we_i,
    input  rtos_op_pkg::op_e                      cmd_op_i,
    input  logic [rtos_cfg_pkg::ID_WIDTH-1:0]     cmd_id_i,
    input  logic [rtos_cfg_pkg::WB_DAT_WIDTH-1:0] cmd_data_i,
    input  logic [TSKID_WIDTH-1:0]                top_tskid_i,
    output logic [TSKID_WIDTH-1:0]                run_tskid_o,
    output logic                                  irq_enable_o,
    output logic                                  irq_o
);
    import rtos_op_pkg::*;

    logic ctl_cmd;
    logic irq_force;
    logic mismatch;
    logic switch_req;
    logic irq_reg;

    assign ctl_cmd  = cmd_valid_i && (cmd_op_i == CPU_CTL);
    assign mismatch = (top_tskid_i != run_tskid_o);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_tskid_o  <= '0;
            irq_enable_o <= 1'b0;
            irq_force    <= 1'b0;
            switch_req   <= 1'b0;
            irq_reg      <= 1'b0;
        end else begin
            if (ctl_cmd && cmd_we_i) begin
                case (cpu_ctl_e'(cmd_id_i))
                    CPU_CTL_RUN_TSKID:  run_tskid_o  <= TSKID_WIDTH'(cmd_data_i);
                    CPU_CTL_COPY_TSKID: run_tskid_o  <= TSKID_WIDTH'(cmd_data_i);
                    CPU_CTL_IRQ_EN:     irq_enable_o <= cmd_data_i[0];
                    CPU_CTL_IRQ_FORCE:  irq_force    <= cmd_data_i[0];
                    default:            ;
                endcase
            end else if (ctl_cmd && cmd_id_i == CPU_CTL_COPY_TSKID) begin
                // copy on read
                run_tskid_o <= top_tskid_i;
            end

            // interrupt once top and run disagree for two cycles
            switch_req <= mismatch;
            irq_reg    <= mismatch && switch_req;
        end
    end

    assign irq_o = (irq_reg && irq_enable_o) || irq_force;

endmodule

// ==== src/rtos_systim.sv ====
/*
 * System time
 * Prescaled 64-bit counter, loaded from a staging register written in
 * two halves, read through a capture register
 */
module rtos_systim (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic                                  cmd_valid_i,
    input  rtos_op_pkg::op_e                      cmd_op_i,
    input  logic [rtos_cfg_pkg::WB_DAT_WIDTH-1:0] cmd_data_i,
    output logic [rtos_cfg_pkg::SYSTIM_WIDTH-1:0] systim_rd_o
);
    import rtos_cfg_pkg::*;
    import rtos_op_pkg::*;

    logic [PRESCL_WIDTH-1:0] prescl;
    logic [PRESCL_WIDTH-1:0] pscl_cnt;
    logic                    tick;
    logic [SYSTIM_WIDTH-1:0] systim;
    logic [SYSTIM_WIDTH-1:0] systim_stage;

    // prescale 0 ticks every cycle
    assign tick = (pscl_cnt == prescl);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prescl   <= '0;
            pscl_cnt <= '0;
            systim   <= '0;
        end else begin
            if (cmd_valid_i && cmd_op_i == SET_PSCL) begin
                prescl   <= PRESCL_WIDTH'(cmd_data_i);
                pscl_cnt <= '0;
            end else begin
                pscl_cnt <= tick ? '0 : pscl_cnt + 1'b1;
            end

            if (cmd_valid_i && cmd_op_i == SET_TIM) begin
                systim <= systim_stage;
            end else if (tick) begin
                systim <= systim + 1'b1;
            end
        end
    end

    // staging halves and capture
    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            case (cmd_op_i)
                SYSTIM_LO: systim_stage[WB_DAT_WIDTH-1:0]            <= cmd_data_i;
                SYSTIM_HI: systim_stage[SYSTIM_WIDTH-1:WB_DAT_WIDTH] <= cmd_data_i;
                GET_TIM:   systim_rd_o                               <= systim;
                default:   ;
            endcase
        end
    end

endmodule

// ==== src/rtos_event_flag.sv ====
/*
 * Event flag
 * Pattern set and cleared by software, plus masked external set
 */
module rtos_event_flag #(
    parameter int FLGPTN_WIDTH = rtos_cfg_pkg::DEF_FLGPTN_WIDTH
) (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic                                  cmd_valid_i,
    input  rtos_op_pkg::op_e                      cmd_op_i,
    input  logic [rtos_cfg_pkg::WB_DAT_WIDTH-1:0] cmd_data_i,
    input  logic [FLGPTN_WIDTH-1:0]               ext_set_flg_i,
    output logic [FLGPTN_WIDTH-1:0]               flgptn_o
);
    import rtos_op_pkg::*;

    logic [FLGPTN_WIDTH-1:0] ext_enable;
    logic [FLGPTN_WIDTH-1:0] flgptn_next;

    // clear first, then software set, then external set
    always_comb begin
        flgptn_next = flgptn_o;
        if (cmd_valid_i && cmd_op_i == CLR_FLG) begin
            flgptn_next = flgptn_next & FLGPTN_WIDTH'(cmd_data_i);
        end
        if (cmd_valid_i && cmd_op_i == SET_FLG) begin
            flgptn_next = flgptn_next | FLGPTN_WIDTH'(cmd_data_i);
        end
        flgptn_next = flgptn_next | (ext_set_flg_i & ext_enable);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flgptn_o   <= '0;
            ext_enable <= '0;
        end else begin
            flgptn_o <= flgptn_next;
            if (cmd_valid_i && cmd_op_i == ENA_FLG_EXT) begin
                ext_enable <= FLGPTN_WIDTH'(cmd_data_i);
            end
        end
    end

endmodule

// ==== src/rtos_ready_queue.sv ====
/*
 * Ready queue
 * One ready bit per task, the lowest ready id is the top task
 */
module rtos_ready_queue #(
    parameter int TMAX_TSKID = rtos_cfg_pkg::DEF_TMAX_TSKID,
    localparam int TSKID_WIDTH = $clog2(TMAX_TSKID + 1)
) (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  logic                              cmd_valid_i,
    input  rtos_op_pkg::op_e                  cmd_op_i,
    input  logic [rtos_cfg_pkg::ID_WIDTH-1:0] cmd_id_i,
    output logic [TMAX_TSKID:1]               rdy_bits_o,
    output logic [TSKID_WIDTH-1:0]            top_tskid_o
);
    import rtos_op_pkg::*;

    // ids 0 and above the maximum never match
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdy_bits_o <= '0;
        end else if (cmd_valid_i) begin
            for (int i = 1; i <= TMAX_TSKID; i++) begin
                if (int'(cmd_id_i) == i) begin
                    if (cmd_op_i == WUP_TSK) begin
                        rdy_bits_o[i] <= 1'b1;
                    end else if (cmd_op_i == SLP_TSK) begin
                        rdy_bits_o[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // scan downward so the lowest ready id wins
    always_comb begin
        top_tskid_o = '0;
        for (int i = TMAX_TSKID; i >= 1; i--) begin
            if (rdy_bits_o[i]) begin
                top_tskid_o = TSKID_WIDTH'(i);
            end
        end
    end

endmodule

// ==== src/rtos_wb_decode.sv ====
/*
 * Wishbone classic slave of the RTOS
 * Splits the address into opcode and id, registers ack, the command
 * pulse and the read data
 */
module rtos_wb_decode #(
    parameter int TMAX_TSKID   = rtos_cfg_pkg::DEF_TMAX_TSKID,
    parameter int FLGPTN_WIDTH = rtos_cfg_pkg::DEF_FLGPTN_WIDTH,
    parameter int CLOCK_RATE   = rtos_cfg_pkg::DEF_CLOCK_RATE,
    localparam int TSKID_WIDTH = $clog2(TMAX_TSKID + 1)
) (
    input  logic                                   clk,
    input  logic                                   arst_n_i,
    input  logic [rtos_cfg_pkg::WB_ADR_WIDTH-1:0]  wb_adr_i,
    input  logic [rtos_cfg_pkg::WB_DAT_WIDTH-1:0]  wb_dat_i,
    input  logic                                   wb_we_i,
    input  logic [rtos_cfg_pkg::WB_SEL_WIDTH-1:0]  wb_sel_i,
    input  logic                                   wb_cyc_i,
    input  logic                                   wb_stb_i,
    output logic                                   wb_ack_o,
    output logic [rtos_cfg_pkg::WB_DAT_WIDTH-1:0]  wb_dat_o,
    input  logic [TMAX_TSKID:1]                    rdy_bits_i,
    input  logic [TSKID_WIDTH-1:0]                 top_tskid_i,
    input  logic [TSKID_WIDTH-1:0]                 run_tskid_i,
    input  logic                                   irq_enable_i,
    input  logic                                   irq_i,
    input  logic [FLGPTN_WIDTH-1:0]                flgptn_i,
    input  logic [rtos_cfg_pkg::SYSTIM_WIDTH-1:0]  systim_rd_i,
    output logic                                   cmd_valid_o,
    output logic                                   cmd_we_o,
    output rtos_op_pkg::op_e                       cmd_op_o,
    output logic [rtos_cfg_pkg::ID_WIDTH-1:0]      cmd_id_o,
    output logic [rtos_cfg_pkg::WB_DAT_WIDTH-1:0]  cmd_data_o
);
    import rtos_cfg_pkg::*;
    import rtos_op_pkg::*;

    op_e                     dec_op;
    logic [ID_WIDTH-1:0]     dec_id;
    logic                    access;
    logic                    wr_full;
    logic                    copy_rd;
    logic [WB_DAT_WIDTH-1:0] rd_data;

    assign dec_op  = op_e'(wb_adr_i[OPCODE_POS +: OPCODE_WIDTH]);
    assign dec_id  = wb_adr_i[ID_POS +: ID_WIDTH];
    // first sample of a strobe while ack is low
    assign access  = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_full = wb_we_i && (&wb_sel_i);
    assign copy_rd = !wb_we_i && (dec_op == CPU_CTL) && (dec_id == CPU_CTL_COPY_TSKID);

    // --------------------
    // read mux
    always_comb begin
        rd_data = '0;
        case (dec_op)
            SYS_CFG: begin
                case (sys_cfg_e'(dec_id))
                    SYS_CFG_CORE_ID:    rd_data = WB_DAT_WIDTH'(CORE_ID);
                    SYS_CFG_VERSION:    rd_data = WB_DAT_WIDTH'(CORE_VERSION);
                    SYS_CFG_CLOCK_RATE: rd_data = WB_DAT_WIDTH'(CLOCK_RATE);
                    SYS_CFG_TMAX_TSKID: rd_data = WB_DAT_WIDTH'(TMAX_TSKID);
                    default:            rd_data = '0;
                endcase
            end
            CPU_CTL: begin
                case (cpu_ctl_e'(dec_id))
                    CPU_CTL_TOP_TSKID:  rd_data = WB_DAT_WIDTH'(top_tskid_i);
                    CPU_CTL_RUN_TSKID:  rd_data = WB_DAT_WIDTH'(run_tskid_i);
                    CPU_CTL_COPY_TSKID: rd_data = WB_DAT_WIDTH'(top_tskid_i);
                    CPU_CTL_IRQ_EN:     rd_data = WB_DAT_WIDTH'(irq_enable_i);
                    CPU_CTL_IRQ_STS:    rd_data = WB_DAT_WIDTH'(irq_i);
                    default:            rd_data = '0;
                endcase
            end
            // bit n is task n
            REF_RDYQUE: rd_data = WB_DAT_WIDTH'({rdy_bits_i, 1'b0});
            REF_FLGPTN: rd_data = WB_DAT_WIDTH'(flgptn_i);
            SYSTIM_LO:  rd_data = WB_DAT_WIDTH'(systim_rd_i);
            SYSTIM_HI:  rd_data = WB_DAT_WIDTH'(systim_rd_i >> WB_DAT_WIDTH);
            default:    rd_data = '0;
        endcase
    end

    // --------------------
    // handshake
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o    <= 1'b0;
            cmd_valid_o <= 1'b0;
        end else begin
            wb_ack_o    <= access;
            cmd_valid_o <= access && (wr_full || copy_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_o   <= rd_data;
            cmd_we_o   <= wb_we_i;
            cmd_op_o   <= dec_op;
            cmd_id_o   <= dec_id;
            cmd_data_o <= wb_dat_i;
        end
    end

endmodule

// ==== src/rtos_op_pkg.sv ====
/*
 * RTOS register map
 * Opcodes of the upper address byte and ids of the lower byte
 */
package rtos_op_pkg;

    typedef enum logic [rtos_cfg_pkg::OPCODE_WIDTH-1:0] {
        SYS_CFG     = 8'h00,
        CPU_CTL     = 8'h01,
        WUP_TSK     = 8'h10,
        SLP_TSK     = 8'h11,
        SET_FLG     = 8'h31,
        CLR_FLG     = 8'h32,
        ENA_FLG_EXT = 8'h3a,
        SET_TIM     = 8'h70,
        SET_PSCL    = 8'h72,
        REF_RDYQUE  = 8'h9f,
        REF_FLGPTN  = 8'hb0,
        GET_TIM     = 8'hf0,
        SYSTIM_LO   = 8'hf2,
        SYSTIM_HI   = 8'hf3
    } op_e;

    // read-only ids under SYS_CFG
    typedef enum logic [rtos_cfg_pkg::ID_WIDTH-1:0] {
        SYS_CFG_CORE_ID    = 8'h00,
        SYS_CFG_VERSION    = 8'h01,
        SYS_CFG_CLOCK_RATE = 8'h07,
        SYS_CFG_TMAX_TSKID = 8'h20
    } sys_cfg_e;

    typedef enum logic [rtos_cfg_pkg::ID_WIDTH-1:0] {
        CPU_CTL_TOP_TSKID  = 8'h00,
        CPU_CTL_RUN_TSKID  = 8'h04,
        CPU_CTL_COPY_TSKID = 8'h08,
        CPU_CTL_IRQ_EN     = 8'h10,
        CPU_CTL_IRQ_STS    = 8'h11,
        CPU_CTL_IRQ_FORCE  = 8'h1f
    } cpu_ctl_e;

endpackage

// ==== src/rtos_cfg_pkg.sv ====
/*
 * RTOS configuration package
 * Bus widths, address field layout, size defaults and identity words
 */
package rtos_cfg_pkg;

    // --------------------
    // bus
    localparam int WB_ADR_WIDTH = 16;
    localparam int WB_DAT_WIDTH = 32;
    localparam int WB_SEL_WIDTH = WB_DAT_WIDTH / 8;

    // opcode in the upper address byte and id in the lower
    localparam int ID_POS       = 0;
    localparam int ID_WIDTH     = 8;
    localparam int OPCODE_POS   = 8;
    localparam int OPCODE_WIDTH = 8;

    // --------------------
    // kernel sizes
    localparam int SYSTIM_WIDTH     = 64;
    localparam int PRESCL_WIDTH     = 32;
    localparam int DEF_TMAX_TSKID   = 15;
    localparam int DEF_FLGPTN_WIDTH = 32;
    localparam int DEF_CLOCK_RATE   = 100000000;

    // identity
    localparam logic [31:0] CORE_ID      = 32'h834f_5452;
    localparam logic [31:0] CORE_VERSION = 32'h0001_0000;

endpackage
